// File: compile.f
logic/seg_pkg.sv
logic/steer_en.sv
logic/balance_cntrl.sv
logic/mtr_drv.sv
logic/seg_core.sv
verif/seg_sva.sv
verif/seg_tb.sv

// File: logic/balance_cntrl.sv
`timescale 1ns/1ns
`default_nettype none

module balance_cntrl (
  input  wire                              clk,
  input  wire                              rst_n,
  input  wire                              vld,          // new pitch reading strobe
  input  wire signed [15:0]                ptch,         // measured pitch
  input  wire signed [seg_pkg::ld_w-1:0]   ld_cell_diff, // lft_ld - rght_ld
  input  wire                              rider_off,
  input  wire                              en_steer,
  input  wire                              pwr_up,       // motors enabled
  input  wire                              fast_sim,     // coarse integrator scaling
  output logic [seg_pkg::spd_w-1:0]        lft_spd,
  output logic                             lft_rev,      // 1 = reverse
  output logic [seg_pkg::spd_w-1:0]        rght_spd,
  output logic                             rght_rev,
  output logic                             too_fast
);

  import seg_pkg::*;

  localparam int trq_w = 18;                               // internal torque width

  localparam logic signed [4:0]       p_coeff      = 5'sd14;
  localparam logic signed [5:0]       d_coeff      = 6'sd20;
  localparam logic [trq_w-1:0]        low_trq_band = 18'd70;   // 5 * p_coeff
  localparam logic signed [trq_w-1:0] gain_mult    = 18'sd15;
  localparam logic signed [trq_w-1:0] min_duty     = 18'sd980;
  localparam logic [spd_w-1:0]        ovr_spd      = 11'd1536;

  logic signed [9:0]        err_sat;     // pitch clipped to 10 bits
  logic signed [14:0]       p_term;

  logic signed [17:0]       integ;       // integrator state
  logic signed [17:0]       err_ext;
  logic signed [17:0]       integ_sum;
  logic                     ov;
  logic signed [15:0]       i_term;

  logic signed [9:0]        err_d1;      // error one strobe back
  logic signed [9:0]        err_d2;      // two strobes back
  logic signed [10:0]       d_diff;
  logic signed [6:0]        d_sat;
  logic signed [12:0]       d_term;

  logic signed [trq_w-1:0]  pid;
  logic signed [trq_w-1:0]  steer_trm;
  logic signed [trq_w-1:0]  lft_trq;
  logic signed [trq_w-1:0]  rght_trq;

  // torque shaping, gives {rev, spd}
  function automatic logic [spd_w:0] shape_trq(input logic signed [trq_w-1:0] trq,
                                               input logic pwr);
    logic [trq_w-1:0]        trq_abs;
    logic signed [trq_w-1:0] shaped;
    logic [trq_w-1:0]        shp_abs;
    logic [spd_w-1:0]        spd;
    trq_abs = trq[trq_w-1] ? -trq : trq;
    if (trq_abs >= low_trq_band)
      shaped = trq[trq_w-1] ? (trq - min_duty) : (trq + min_duty);  // push past deadband
    else
      shaped = trq * gain_mult;                                      // steeper near zero
    shp_abs = shaped[trq_w-1] ? -shaped : shaped;
    if (!pwr)
      spd = '0;
    else if (|shp_abs[trq_w-1:spd_w])
      spd = '1;                                                      // clamp at 2047
    else
      spd = shp_abs[spd_w-1:0];
    return {shaped[trq_w-1], spd};
  endfunction

  ////////////////////
  // p term
  ////////////////////

  assign err_sat = (ptch[15] && !(&ptch[14:9])) ? 10'h200 :
                   (!ptch[15] && (|ptch[14:9])) ? 10'h1FF :
                   ptch[9:0];
  assign p_term  = err_sat * p_coeff;

  ////////////////////
  // i term
  ////////////////////

  assign err_ext   = trq_w'(err_sat);
  assign integ_sum = integ + err_ext;
  // same input signs but result sign flipped
  assign ov = (integ[17] == err_ext[17]) && (integ_sum[17] != integ[17]);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)                    integ <= '0;
    else if (rider_off || !pwr_up) integ <= '0;          // nobody riding, drop windup
    else if (vld && !ov)           integ <= integ_sum;   // hold at the rail on overflow
  end

  assign i_term = fast_sim ? $signed(integ[17:2]) : $signed({{4{integ[17]}}, integ[17:6]});

  ////////////////////
  // d term
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_d1 <= '0;
      err_d2 <= '0;
    end else if (vld) begin
      err_d1 <= err_sat;
      err_d2 <= err_d1;
    end
  end

  assign d_diff = 11'(err_sat) - 11'(err_d2);   // one extra bit so no wrap
  assign d_sat  = (d_diff[10] && !(&d_diff[9:6])) ? 7'h40 :
                  (!d_diff[10] && (|d_diff[9:6])) ? 7'h3F :
                  d_diff[6:0];
  assign d_term = d_sat * d_coeff;

  ////////////////////
  // mix and shape
  ////////////////////

  assign pid       = trq_w'(p_term) + trq_w'(i_term) + trq_w'(d_term);
  assign steer_trm = trq_w'(ld_cell_diff >>> 3);                // diff / 8
  assign lft_trq   = en_steer ? (pid - steer_trm) : pid;
  assign rght_trq  = en_steer ? (pid + steer_trm) : pid;

  assign {lft_rev, lft_spd}   = shape_trq(lft_trq, pwr_up);
  assign {rght_rev, rght_spd} = shape_trq(rght_trq, pwr_up);

  assign too_fast = (lft_spd > ovr_spd) || (rght_spd > ovr_spd);

endmodule

`default_nettype wire

// File: logic/mtr_drv.sv
`timescale 1ns/1ns
`default_nettype none

module mtr_drv (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire [seg_pkg::spd_w-1:0]     lft_spd,    // left duty
  input  wire [seg_pkg::spd_w-1:0]     rght_spd,   // right duty
  output logic                         pwm_lft,
  output logic                         pwm_rght
);

  import seg_pkg::*;

  logic [spd_w-1:0] pwm_cnt;   // shared by both sides, 2048 cycle period

  ////////////////////
  // period counter
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) pwm_cnt <= '0;
    else        pwm_cnt <= pwm_cnt + 1'b1;   // free running, wraps
  end

  ////////////////////
  // duty compare
  ////////////////////

  // high while count is under the speed, so spd highs per period
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pwm_lft  <= 1'b0;
      pwm_rght <= 1'b0;
    end else begin
      pwm_lft  <= (pwm_cnt < lft_spd);
      pwm_rght <= (pwm_cnt < rght_spd);
    end
  end

endmodule

`default_nettype wire

// File: logic/seg_core.sv
`timescale 1ns/1ns
`default_nettype none

module seg_core #(
  parameter int TMR_W = 26                              // settle timer width
) (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          vld,        // pitch strobe
  input  wire signed [15:0]            ptch,
  input  wire [seg_pkg::ld_w-1:0]      lft_ld,
  input  wire [seg_pkg::ld_w-1:0]      rght_ld,
  input  wire                          pwr_up,
  input  wire                          fast_sim,
  output logic [seg_pkg::spd_w-1:0]    lft_spd,
  output logic [seg_pkg::spd_w-1:0]    rght_spd,
  output logic                         lft_rev,
  output logic                         rght_rev,
  output logic                         too_fast,
  output logic                         rider_off,
  output logic                         en_steer,
  output logic                         pwm_lft,
  output logic                         pwm_rght
);

  import seg_pkg::*;

  logic signed [ld_w-1:0] ld_cell_diff;   // steer_en to balance_cntrl

  ////////////////////
  // rider and steering
  ////////////////////

  steer_en #(
    .TMR_W        (TMR_W)
  ) u_steer (
    .clk          (clk),
    .rst_n        (rst_n),
    .lft_ld       (lft_ld),
    .rght_ld      (rght_ld),
    .rider_off    (rider_off),
    .en_steer     (en_steer),
    .ld_cell_diff (ld_cell_diff)
  );

  ////////////////////
  // pid loop
  ////////////////////

  balance_cntrl u_bal (
    .clk          (clk),
    .rst_n        (rst_n),
    .vld          (vld),
    .ptch         (ptch),
    .ld_cell_diff (ld_cell_diff),
    .rider_off    (rider_off),
    .en_steer     (en_steer),
    .pwr_up       (pwr_up),
    .fast_sim     (fast_sim),
    .lft_spd      (lft_spd),
    .lft_rev      (lft_rev),
    .rght_spd     (rght_spd),
    .rght_rev     (rght_rev),
    .too_fast     (too_fast)
  );

  ////////////////////
  // motor pwm
  ////////////////////

  mtr_drv u_mtr (
    .clk          (clk),
    .rst_n        (rst_n),
    .lft_spd      (lft_spd),
    .rght_spd     (rght_spd),
    .pwm_lft      (pwm_lft),
    .pwm_rght     (pwm_rght)
  );

endmodule

`default_nettype wire

// File: logic/seg_pkg.sv
`default_nettype none

package seg_pkg;

  ////////////////////
  // widths
  ////////////////////

  // one load cell reading, unsigned
  localparam int ld_w = 12;

  // motor speed, also the pwm counter width
  localparam int spd_w = 11;

  ////////////////////
  // rider detection
  ////////////////////

  // combined load below this means nobody on the platform
  localparam logic [ld_w-1:0] min_rider_wt = 12'h200;

  ////////////////////
  // steering fsm
  ////////////////////

  typedef enum logic [1:0] {
    st_idle,   // no rider
    st_wait,   // rider on, waiting for a balanced stance
    st_steer   // steering enabled
  } steer_state_t;

endpackage

`default_nettype wire

// File: logic/steer_en.sv
`timescale 1ns/1ns
`default_nettype none

module steer_en #(
  parameter int TMR_W = 26                                // settle timer width
) (
  input  wire                                    clk,
  input  wire                                    rst_n,
  input  wire [seg_pkg::ld_w-1:0]                lft_ld,   // left load cell
  input  wire [seg_pkg::ld_w-1:0]                rght_ld,  // right load cell
  output logic                                   rider_off,
  output logic                                   en_steer,
  output logic signed [seg_pkg::ld_w-1:0]        ld_cell_diff
);

  import seg_pkg::*;

  logic        [ld_w:0]   ld_sum;     // one extra bit, no wrap
  logic signed [ld_w:0]   ld_diff;    // full range left minus right
  logic        [ld_w:0]   abs_diff;
  logic        [ld_w-1:0] diff_sat;
  logic                   rider_on;
  logic                   bal_ok;     // diff below sum/4
  logic                   unbal;      // diff above 15/16 of sum

  steer_state_t           state;
  steer_state_t           nxt_state;

  logic [TMR_W-1:0]       tmr;        // settle timer
  logic                   tmr_clr;
  logic                   tmr_inc;
  logic                   tmr_full;

  ////////////////////
  // load arithmetic
  ////////////////////

  assign ld_sum   = {1'b0, lft_ld} + {1'b0, rght_ld};
  assign ld_diff  = $signed({1'b0, lft_ld}) - $signed({1'b0, rght_ld});
  assign abs_diff = ld_diff[ld_w] ? -ld_diff : ld_diff;

  // clip to 12 bit signed when the top two bits disagree
  assign diff_sat = (ld_diff[ld_w] != ld_diff[ld_w-1]) ?
                    (ld_diff[ld_w] ? {1'b1, {(ld_w-1){1'b0}}} : {1'b0, {(ld_w-1){1'b1}}}) :
                    ld_diff[ld_w-1:0];

  assign rider_on = (ld_sum >= {1'b0, min_rider_wt});
  assign bal_ok   = (abs_diff < (ld_sum >> 2));              // shift, no divider
  assign unbal    = (abs_diff > (ld_sum - (ld_sum >> 4)));   // sum - sum/16
  assign tmr_full = &tmr;

  // registered rider flag and difference
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rider_off    <= 1'b1;          // assume empty platform
      ld_cell_diff <= '0;
    end else begin
      rider_off    <= !rider_on;
      ld_cell_diff <= diff_sat;
    end
  end

  ////////////////////
  // steering fsm
  ////////////////////

  always_comb begin
    nxt_state = state;
    tmr_clr   = 1'b0;
    tmr_inc   = 1'b0;
    case (state)
      st_idle: begin
        tmr_clr = 1'b1;
        if (rider_on) nxt_state = st_wait;
      end
      st_wait: begin
        if (!bal_ok) begin
          tmr_clr = 1'b1;                // stance moved, start over
        end else if (tmr_full) begin
          nxt_state = st_steer;
          tmr_clr   = 1'b1;
        end else begin
          tmr_inc = 1'b1;
        end
      end
      st_steer: begin
        if (unbal) begin                 // rider stepping off one side
          nxt_state = st_wait;
          tmr_clr   = 1'b1;
        end
      end
      default: nxt_state = st_idle;
    endcase
    // rider gone overrides everything
    if (!rider_on) begin
      nxt_state = st_idle;
      tmr_clr   = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) state <= st_idle;
    else        state <= nxt_state;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)       tmr <= '0;
    else if (tmr_clr) tmr <= '0;
    else if (tmr_inc) tmr <= tmr + 1'b1;
  end

  assign en_steer = (state == st_steer);   // comes straight off the state flops

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# build and run the seg_core testbench with verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

log=sim.log
rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal \
  --top-module seg_tb \
  -f compile.f \
  -o seg_tb_sim

./obj_dir/seg_tb_sim | tee "$log"

if grep -q "Test failed" "$log"; then
  echo "simulation reported a failure"
  exit 1
fi
echo "simulation finished without failure"

// File: verif/seg_sva.sv
`timescale 1ns/1ns
`default_nettype none

module seg_sva (
  input wire                      clk,
  input wire                      rst_n,
  input wire                      pwr_up,
  input wire                      rider_off,
  input wire                      en_steer,
  input wire                      too_fast,
  input wire [seg_pkg::spd_w-1:0] lft_spd,
  input wire [seg_pkg::spd_w-1:0] rght_spd,
  input wire seg_pkg::steer_state_t steer_state   // steer_en fsm state
);

  import seg_pkg::*;

  localparam int ovr_lim = 1536;   // overspeed threshold

  ////////////////////
  // steering
  ////////////////////

  a_steer_rider: assert property (@(posedge clk) disable iff (!rst_n)
    en_steer |-> !rider_off)
    else $error("en_steer high while rider_off is high");

  a_steer_state: assert property (@(posedge clk) disable iff (!rst_n)
    en_steer |-> (steer_state == st_steer))
    else $error("en_steer high outside the steer state");

  ////////////////////
  // motor outputs
  ////////////////////

  a_pwr_off: assert property (@(posedge clk) disable iff (!rst_n)
    !pwr_up |-> (lft_spd == '0 && rght_spd == '0))
    else $error("nonzero speed with pwr_up low");

  a_too_fast: assert property (@(posedge clk) disable iff (!rst_n)
    too_fast == ((lft_spd > ovr_lim) || (rght_spd > ovr_lim)))
    else $error("too_fast disagrees with the speed limit");

endmodule

bind seg_core seg_sva sva0 (
  .clk         (clk),
  .rst_n       (rst_n),
  .pwr_up      (pwr_up),
  .rider_off   (rider_off),
  .en_steer    (en_steer),
  .too_fast    (too_fast),
  .lft_spd     (lft_spd),
  .rght_spd    (rght_spd),
  .steer_state (u_steer.state)
);

`default_nettype wire

// File: verif/seg_tb.sv
`timescale 1ns/1ns
`default_nettype none

module seg_tb;

  import seg_pkg::*;

  localparam int tmr_w      = 6;                    // short settle timer for sim
  localparam int steer_max  = 2**tmr_w + 3;         // latest allowed en_steer rise
  // load phases, vld strobes and pwm periods plus margin
  localparam int max_cycles = 6*200 + 400*4 + 3*2048 + 2000;

  logic               clk;
  logic               rst_n;
  logic               vld;
  logic signed [15:0] ptch;
  logic [ld_w-1:0]    lft_ld;
  logic [ld_w-1:0]    rght_ld;
  logic               pwr_up;
  logic               fast_sim;
  logic [spd_w-1:0]   lft_spd;
  logic [spd_w-1:0]   rght_spd;
  logic               lft_rev, rght_rev, too_fast;
  logic               rider_off, en_steer, pwm_lft, pwm_rght;

  // reference model state
  int     m_integ, m_d1, m_d2;   // integrator and error history
  int     m_lspd, m_rspd;        // last expected speeds
  logic   steer_exp;             // steering expected on
  integer seed;
  int     cycle_cnt = 0;

  seg_core #(.TMR_W(tmr_w)) dut0 (
    .clk(clk), .rst_n(rst_n), .vld(vld), .ptch(ptch),
    .lft_ld(lft_ld), .rght_ld(rght_ld), .pwr_up(pwr_up), .fast_sim(fast_sim),
    .lft_spd(lft_spd), .rght_spd(rght_spd), .lft_rev(lft_rev), .rght_rev(rght_rev),
    .too_fast(too_fast), .rider_off(rider_off), .en_steer(en_steer),
    .pwm_lft(pwm_lft), .pwm_rght(pwm_rght)
  );

  always #20 clk = ~clk;   // 40 ns period

  // run limit
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > max_cycles) begin
      $display("timeout, the run went past %0d clock cycles", max_cycles);
      $display("Test failed");
      $fatal(1, "run limit reached");
    end
  end

  task automatic check_val(input string name, input logic [31:0] exp_v,
                           input logic [31:0] act_v);
    if (exp_v !== act_v) begin
      $display("FAIL %s expected %0d actual %0d", name, exp_v, act_v);
      $display("Test failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  ////////////////////
  // model arithmetic
  ////////////////////

  function automatic int clip(input int v, input int lo, input int hi);
    if (v < lo) return lo;
    if (v > hi) return hi;
    return v;
  endfunction

  // deadband push for big torque, steep gain near zero
  function automatic int shape(input int trq);
    if (trq >= 70) return trq + 980;
    if (trq <= -70) return trq - 980;
    return trq * 15;
  endfunction

  function automatic int to_spd(input int shaped, input logic pwr);
    int mag;
    mag = (shaped < 0) ? -shaped : shaped;
    if (!pwr) return 0;
    return clip(mag, 0, 2047);
  endfunction

  // half full range, half scaled down into the linear band
  function automatic int rand_ptch(input logic [31:0] r);
    if (r[0]) return int'($signed(r[31:16]));
    return int'($signed(r[31:16])) >>> 6;
  endfunction

  task automatic drive_loads(input int l, input int r);
    @(posedge clk);
    lft_ld  <= ld_w'(l);
    rght_ld <= ld_w'(r);
  endtask

  // one vld strobe, model update, output compare; 4 cycles per call
  task automatic strobe(input int p, input logic fs, input string tag);
    int   err, sum, i_t, d_t, pid, st, lsh, rsh;
    logic rider_exp;
    @(posedge clk);
    vld      <= 1'b1;
    ptch     <= 16'(p);
    fast_sim <= fs;
    @(posedge clk);                                  // dut takes the strobe here
    vld <= 1'b0;
    rider_exp = (int'(lft_ld) + int'(rght_ld)) < int'(min_rider_wt);
    err = clip(p, -512, 511);
    if (rider_exp || !pwr_up) begin
      m_integ = 0;
    end else begin
      sum = m_integ + err;
      if (sum <= 131071 && sum >= -131072) m_integ = sum;   // hold on 18 bit overflow
    end
    m_d2 = m_d1;
    m_d1 = err;
    i_t = fs ? (m_integ >>> 2) : (m_integ >>> 6);
    d_t = clip(err - m_d2, -64, 63) * 20;
    pid = err * 14 + i_t + d_t;
    st  = steer_exp ? (clip(int'(lft_ld) - int'(rght_ld), -2048, 2047) >>> 3) : 0;
    lsh = shape(pid - st);
    rsh = shape(pid + st);
    m_lspd = to_spd(lsh, pwr_up);
    m_rspd = to_spd(rsh, pwr_up);
    @(negedge clk);                                  // outputs settled
    check_val({tag, "_lft_spd"}, m_lspd, lft_spd);
    check_val({tag, "_rght_spd"}, m_rspd, rght_spd);
    check_val({tag, "_lft_rev"}, lsh < 0, lft_rev);
    check_val({tag, "_rght_rev"}, rsh < 0, rght_rev);
    check_val({tag, "_too_fast"}, (m_lspd > 1536) || (m_rspd > 1536), too_fast);
    check_val({tag, "_rider_off"}, rider_exp, rider_off);
    check_val({tag, "_en_steer"}, steer_exp, en_steer);
    if (!steer_exp) check_val({tag, "_lr_equal"}, m_lspd, rght_spd);
    if (!pwr_up) check_val({tag, "_pwm_low"}, 0, pwm_lft | pwm_rght);
    @(posedge clk);
    @(posedge clk);
  endtask

  task automatic wait_steer(input string tag);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!en_steer && n < steer_max);
    check_val(tag, 1, (en_steer && n >= 2**tmr_w) ? 1 : 0);   // not early, not late
  endtask

  // every counter value shows up once in 2048 cycles
  task automatic count_pwm(input string tag);
    int hl, hr;
    hl = 0;
    hr = 0;
    repeat (2048) begin
      @(negedge clk);
      hl += pwm_lft;
      hr += pwm_rght;
    end
    check_val({tag, "_lft_highs"}, m_lspd, hl);
    check_val({tag, "_rght_highs"}, m_rspd, hr);
  endtask

  ////////////////////
  // test sequence
  ////////////////////

  initial begin
    logic [31:0] r;
    int          p;
    seed = 30;
    m_integ = 0;
    m_d1 = 0;
    m_d2 = 0;
    m_lspd = 0;
    m_rspd = 0;
    steer_exp = 1'b0;
    clk = 1'b0;
    rst_n = 1'b0;
    vld = 1'b0;
    ptch = '0;
    lft_ld = '0;
    rght_ld = '0;
    pwr_up = 1'b0;
    fast_sim = 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk);

    // motors off, nobody riding
    repeat (20) begin
      r = $random(seed);
      strobe(rand_ptch(r), r[1], "pwr_off");
    end

    // rider on but lopsided, steering stays off
    drive_loads(1800, 200);
    pwr_up <= 1'b1;
    repeat (3) @(posedge clk);
    for (int i = 0; i < 300; i++) begin
      r = $random(seed);
      p = (i < 280) ? 1024 + int'(r[13:0]) : rand_ptch(r);   // long push drives overflow
      strobe(p, r[1], "pid");
    end

    // rider steps off briefly, integrator drops
    drive_loads(100, 100);
    repeat (5) @(posedge clk);
    m_integ = 0;
    drive_loads(1800, 200);
    repeat (3) @(posedge clk);
    repeat (30) begin
      r = $random(seed);
      strobe(rand_ptch(r), r[1], "integ_clr");
    end

    // steering enable and drop
    drive_loads(1500, 1480);
    wait_steer("steer_rise");
    drive_loads(2000, 20);                  // diff above 15/16 of sum
    repeat (2) @(negedge clk);
    check_val("steer_unbal_en", 0, en_steer);
    check_val("steer_unbal_rider", 0, rider_off);
    drive_loads(1500, 1480);
    wait_steer("steer_rise_again");
    drive_loads(0, 0);
    repeat (2) @(negedge clk);
    check_val("steer_off_en", 0, en_steer);
    check_val("steer_off_rider", 1, rider_off);
    m_integ = 0;
    drive_loads(1500, 1480);
    wait_steer("steer_rise_back");
    steer_exp = 1'b1;

    // steering mix with random balanced stance
    repeat (47) begin
      r = $random(seed);
      drive_loads(1000 + int'(r[9:0]), 1000 + int'(r[25:16]));
      r = $random(seed);
      strobe(rand_ptch(r), r[1], "steer_mix");
    end

    // pwm duty over held speeds
    for (int k = 0; k < 3; k++) begin
      r = $random(seed);
      strobe(rand_ptch(r), r[1], "pwm");
      count_pwm("pwm");
    end

    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire
